// ==== arch_defs_pkg.sv ====
package arch_defs_pkg;

    // ================================================
    // Instruction set
    typedef enum logic [7:0] {
        NOP   = 8'h00,
        HLT   = 8'h01,
        LDI_A = 8'h10,
        LDI_B = 8'h11,
        LDI_C = 8'h12,
        LDA   = 8'h13,
        ADD_B = 8'h20,
        ADD_C = 8'h21,
        ADC_B = 8'h22,
        ADC_C = 8'h23,
        SUB_B = 8'h24,
        SUB_C = 8'h25,
        SBC_B = 8'h26,
        SBC_C = 8'h27,
        INR_A = 8'h28,
        DCR_A = 8'h29,
        ANA_B = 8'h30,
        ANA_C = 8'h31,
        ANI   = 8'h32,
        JMP   = 8'h40,
        JZ    = 8'h41,
        JNZ   = 8'h42,
        JN    = 8'h43
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_UNDEFINED, ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_INR, ALU_DCR, ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_B, SRC_C, SRC_TEMP1
    } alu_src_t;

    // ================================================
    // Sequencing
    typedef enum logic [2:0] {
        S_RESET, S_INIT, S_LATCH_ADDR, S_READ_BYTE,
        S_LATCH_BYTE, S_CHK_MORE_BYTES, S_EXECUTE, S_HALT
    } fsm_state_t;

    typedef enum logic [2:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    typedef struct packed {
        logic     oe_ram;             // Bus drivers
        logic     oe_alu;
        logic     oe_temp_1;
        logic     oe_temp_2;
        logic     load_a;             // Register loads
        logic     load_b;
        logic     load_c;
        logic     load_ir;
        logic     load_temp_1;
        logic     load_temp_2;
        logic     load_flags;
        logic     load_sets_zn;       // Z/N from bus, carry kept
        logic     load_mar_pc;
        logic     load_mar_addr_low;
        logic     load_mar_addr_high;
        logic     load_pc_low_byte;
        logic     load_pc_high_byte;
        logic     load_origin;        // PC to zero
        logic     pc_enable;
        logic     last_step;
        logic     halt;
        logic     check_zero;         // Jump conditions
        logic     check_not_zero;
        logic     check_carry;
        logic     check_negative;
        alu_op_t  alu_op;
        alu_src_t alu_src;
    } control_word_t;

    localparam int FLAG_ZERO  = 0;
    localparam int FLAG_CARRY = 1;
    localparam int FLAG_NEG   = 2;

    // ================================================
    // Top-level ports
    typedef struct packed {
        logic        en;
        logic [15:0] addr;
        logic [7:0]  data;
    } mem_load_t;

    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  c;
        logic [2:0]  flags;
        logic [15:0] pc;
    } cpu_state_t;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ns

module alu import arch_defs_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  alu_op_t    op,
    input  logic [7:0] operand_a,
    input  logic [7:0] operand_b,
    input  logic       carry_in,
    output logic [7:0] result,
    output logic [2:0] flags_out
);

    logic [8:0] sum;
    logic       carry;

    always_comb begin
        carry = carry_in;
        case (op)
            ALU_ADD: sum = {1'b0, operand_a} + {1'b0, operand_b};
            ALU_ADC: sum = {1'b0, operand_a} + {1'b0, operand_b} + {8'd0, carry_in};
            ALU_SUB: sum = {1'b0, operand_a} - {1'b0, operand_b};
            ALU_SBC: sum = {1'b0, operand_a} - {1'b0, operand_b} - {8'd0, carry_in};
            ALU_INR: sum = {1'b0, operand_a + 8'd1};
            ALU_DCR: sum = {1'b0, operand_a - 8'd1};
            ALU_AND: sum = {1'b0, operand_a & operand_b};
            default: sum = 9'd0;
        endcase
        if (op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND}) begin
            carry = sum[8];                          // Borrow on subtract, 0 on AND
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= 8'd0;
            flags_out <= 3'b000;
        end else if (op != ALU_UNDEFINED) begin
            result <= sum[7:0];
            flags_out[FLAG_ZERO] <= (sum[7:0] == 8'd0);
            flags_out[FLAG_CARRY] <= carry;
            flags_out[FLAG_NEG] <= sum[7];
        end
    end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ns

module control_unit import arch_defs_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  opcode_t       opcode,
    input  logic [2:0]    flags,
    output control_word_t control_word,
    output logic          halted
);

    fsm_state_t    current_state;
    fsm_state_t    next_state;
    microstep_t    current_microstep;
    microstep_t    next_microstep;
    logic [1:0]    byte_count;
    logic [1:0]    next_byte_count;
    logic [1:0]    num_operand_bytes;
    logic          opcode_known;
    control_word_t rom_word;
    logic          jump_test;
    logic          jump_taken;

    // ================================================
    // Operand count per opcode
    always_comb begin
        opcode_known = 1'b1;
        num_operand_bytes = 2'd0;
        case (opcode)
            NOP, HLT, ADD_B, ADD_C, ADC_B, ADC_C, SUB_B, SUB_C,
            SBC_B, SBC_C, INR_A, DCR_A, ANA_B, ANA_C: num_operand_bytes = 2'd0;
            LDI_A, LDI_B, LDI_C, ANI:                 num_operand_bytes = 2'd1;
            JMP, JZ, JNZ, JN, LDA:                    num_operand_bytes = 2'd2;
            default:                                  opcode_known = 1'b0;
        endcase
    end

    // ================================================
    // Microcode ROM, eight steps per opcode
    function automatic control_word_t ucode(opcode_t op, microstep_t ms);
        control_word_t cw;
        cw = '0;
        case (op)
            NOP: cw.last_step = 1'b1;
            HLT: cw.halt = 1'b1;
            LDI_A, LDI_B, LDI_C: begin
                cw.oe_temp_1 = 1'b1;
                cw.load_a = (op == LDI_A);
                cw.load_b = (op == LDI_B);
                cw.load_c = (op == LDI_C);
                cw.load_flags = 1'b1;
                cw.load_sets_zn = 1'b1;
                cw.last_step = 1'b1;
            end
            LDA: begin
                case (ms)
                    MS0: cw.oe_temp_1 = 1'b1;
                    MS1: begin
                        cw.oe_temp_1 = 1'b1;
                        cw.load_mar_addr_low = 1'b1;
                    end
                    MS2: cw.oe_temp_2 = 1'b1;
                    MS3: begin
                        cw.oe_temp_2 = 1'b1;
                        cw.load_mar_addr_high = 1'b1;
                    end
                    MS4: cw.oe_ram = 1'b1;           // RAM read in flight
                    default: begin
                        cw.oe_ram = 1'b1;
                        cw.load_a = 1'b1;
                        cw.load_flags = 1'b1;
                        cw.load_sets_zn = 1'b1;
                        cw.last_step = 1'b1;
                    end
                endcase
            end
            JMP, JZ, JNZ, JN: begin
                // Condition is tested on both steps
                cw.check_zero = (op == JZ);
                cw.check_not_zero = (op == JNZ);
                cw.check_negative = (op == JN);
                if (ms == MS0) begin
                    cw.oe_temp_1 = 1'b1;
                    cw.load_pc_low_byte = 1'b1;
                end else begin
                    cw.oe_temp_2 = 1'b1;
                    cw.load_pc_high_byte = 1'b1;
                    cw.last_step = 1'b1;
                end
            end
            ADD_B, ADD_C, ADC_B, ADC_C, SUB_B, SUB_C, SBC_B, SBC_C,
            INR_A, DCR_A, ANA_B, ANA_C, ANI: begin
                if (ms == MS0) begin
                    case (op)
                        ADD_B, ADD_C: cw.alu_op = ALU_ADD;
                        ADC_B, ADC_C: cw.alu_op = ALU_ADC;
                        SUB_B, SUB_C: cw.alu_op = ALU_SUB;
                        SBC_B, SBC_C: cw.alu_op = ALU_SBC;
                        INR_A:        cw.alu_op = ALU_INR;
                        DCR_A:        cw.alu_op = ALU_DCR;
                        default:      cw.alu_op = ALU_AND;
                    endcase
                    case (op)
                        ADD_C, ADC_C, SUB_C, SBC_C, ANA_C: cw.alu_src = SRC_C;
                        ANI:                               cw.alu_src = SRC_TEMP1;
                        default:                           cw.alu_src = SRC_B;
                    endcase
                end else begin
                    cw.oe_alu = 1'b1;                // Write back ALU result
                    cw.load_a = 1'b1;
                    cw.load_flags = 1'b1;
                    cw.last_step = 1'b1;
                end
            end
            default: cw = '0;
        endcase
        return cw;
    endfunction

    assign rom_word = ucode(opcode, current_microstep);

    assign jump_test = rom_word.check_zero || rom_word.check_not_zero ||
                       rom_word.check_carry || rom_word.check_negative;
    assign jump_taken = (rom_word.check_zero && flags[FLAG_ZERO]) ||
                        (rom_word.check_not_zero && !flags[FLAG_ZERO]) ||
                        (rom_word.check_carry && flags[FLAG_CARRY]) ||
                        (rom_word.check_negative && flags[FLAG_NEG]);

    assign halted = (current_state == S_HALT);

    // ================================================
    // State registers
    always_ff @(posedge clk) begin
        if (reset) begin
            current_state <= S_RESET;
            current_microstep <= MS0;
            byte_count <= 2'd0;
        end else begin
            current_state <= next_state;
            current_microstep <= next_microstep;
            byte_count <= next_byte_count;
        end
    end

    // ================================================
    // Fetch and execute sequencing
    always_comb begin
        next_state = current_state;
        next_microstep = current_microstep;
        next_byte_count = byte_count;
        control_word = '0;
        case (current_state)
            S_RESET: next_state = S_INIT;
            S_INIT: begin
                control_word.load_origin = 1'b1;
                next_state = S_LATCH_ADDR;
            end
            S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1;
                next_state = S_READ_BYTE;
            end
            S_READ_BYTE: next_state = S_LATCH_BYTE;  // RAM latency
            S_LATCH_BYTE: begin
                control_word.oe_ram = 1'b1;
                control_word.pc_enable = 1'b1;
                case (byte_count)
                    2'd0:    control_word.load_ir = 1'b1;
                    2'd1:    control_word.load_temp_1 = 1'b1;
                    default: control_word.load_temp_2 = 1'b1;
                endcase
                next_byte_count = byte_count + 2'd1;
                next_state = S_CHK_MORE_BYTES;
            end
            S_CHK_MORE_BYTES: begin
                if (!opcode_known) begin
                    next_state = S_HALT;
                end else if (byte_count > num_operand_bytes) begin
                    next_state = S_EXECUTE;
                    next_byte_count = 2'd0;
                end else begin
                    next_state = S_LATCH_ADDR;
                end
            end
            S_EXECUTE: begin
                control_word = rom_word;
                if (rom_word.halt) begin
                    next_state = S_HALT;
                    next_microstep = MS0;
                end else if (jump_test && !jump_taken) begin
                    control_word.load_pc_low_byte = 1'b0;   // Not taken
                    control_word.load_pc_high_byte = 1'b0;
                    next_state = S_LATCH_ADDR;
                    next_microstep = MS0;
                end else if (rom_word.last_step) begin
                    next_state = S_LATCH_ADDR;
                    next_microstep = MS0;
                end else begin
                    next_microstep = microstep_t'(current_microstep + 3'd1);
                end
            end
            default: next_state = S_HALT;            // Halt holds here
        endcase
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ns

module datapath import arch_defs_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  control_word_t control_word,
    input  logic [7:0]    ram_rdata,
    input  logic [7:0]    alu_result,
    input  logic [2:0]    alu_flags,
    output logic [15:0]   mem_addr,
    output logic [7:0]    alu_operand_a,
    output logic [7:0]    alu_operand_b,
    output opcode_t       opcode,
    output logic [2:0]    flags,
    output cpu_state_t    state
);

    logic [7:0]  bus;
    logic [7:0]  reg_a;
    logic [7:0]  reg_b;
    logic [7:0]  reg_c;
    logic [7:0]  temp_1;
    logic [7:0]  temp_2;
    logic [15:0] pc;
    logic [15:0] mar;

    // ================================================
    // Internal bus, one driver per cycle
    always_comb begin
        if (control_word.oe_alu)         bus = alu_result;
        else if (control_word.oe_ram)    bus = ram_rdata;
        else if (control_word.oe_temp_1) bus = temp_1;
        else if (control_word.oe_temp_2) bus = temp_2;
        else                             bus = 8'd0;
    end

    always_comb begin
        case (control_word.alu_src)
            SRC_C:     alu_operand_b = reg_c;
            SRC_TEMP1: alu_operand_b = temp_1;
            default:   alu_operand_b = reg_b;
        endcase
    end

    // ================================================
    // Architectural registers
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a <= 8'd0;
            reg_b <= 8'd0;
            reg_c <= 8'd0;
            flags <= 3'b000;
            opcode <= NOP;
            pc <= 16'd0;
            mar <= 16'd0;
        end else begin
            if (control_word.load_a) reg_a <= bus;
            if (control_word.load_b) reg_b <= bus;
            if (control_word.load_c) reg_c <= bus;
            if (control_word.load_ir) opcode <= opcode_t'(bus);
            if (control_word.load_flags) begin
                if (control_word.load_sets_zn) begin
                    flags[FLAG_ZERO] <= (bus == 8'd0);   // Carry untouched
                    flags[FLAG_NEG] <= bus[7];
                end else begin
                    flags <= alu_flags;
                end
            end
            if (control_word.load_origin) pc <= 16'd0;
            else if (control_word.load_pc_low_byte) pc[7:0] <= bus;
            else if (control_word.load_pc_high_byte) pc[15:8] <= bus;
            else if (control_word.pc_enable) pc <= pc + 16'd1;
            if (control_word.load_mar_pc) mar <= pc;
            if (control_word.load_mar_addr_low) mar[7:0] <= bus;
            if (control_word.load_mar_addr_high) mar[15:8] <= bus;
        end
    end

    // Operand temporaries
    always_ff @(posedge clk) begin
        if (control_word.load_temp_1) temp_1 <= bus;
        if (control_word.load_temp_2) temp_2 <= bus;
    end

    assign mem_addr = mar;
    assign alu_operand_a = reg_a;
    assign state = '{a: reg_a, b: reg_b, c: reg_c, flags: flags, pc: pc};

endmodule

// ==== ram.sv ====
`timescale 1ns/1ns

module ram import arch_defs_pkg::*; #(
    parameter int MEM_DEPTH = 256
) (
    input  logic        clk,
    input  logic [15:0] addr,
    output logic [7:0]  rdata,
    input  mem_load_t   load
);

    localparam int AW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic [7:0] mem [MEM_DEPTH];

    // Preload wins over the read
    always_ff @(posedge clk) begin
        if (load.en) begin
            mem[load.addr[AW-1:0]] <= load.data;
        end else begin
            rdata <= mem[addr[AW-1:0]];             // Upper bits alias
        end
    end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top import arch_defs_pkg::*; #(
    parameter int MEM_DEPTH = 256
) (
    input  logic       clk,
    input  logic       reset,
    input  mem_load_t  load,
    output logic       halted,
    output cpu_state_t cpu_state
);

    control_word_t control_word;
    opcode_t       opcode;
    logic [2:0]    flags;
    logic [15:0]   mem_addr;
    logic [7:0]    ram_rdata;
    logic [7:0]    alu_result;
    logic [2:0]    alu_flags;
    logic [7:0]    alu_operand_a;
    logic [7:0]    alu_operand_b;

    control_unit i_control_unit (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word),
        .halted       (halted)
    );

    datapath i_datapath (
        .clk           (clk),
        .reset         (reset),
        .control_word  (control_word),
        .ram_rdata     (ram_rdata),
        .alu_result    (alu_result),
        .alu_flags     (alu_flags),
        .mem_addr      (mem_addr),
        .alu_operand_a (alu_operand_a),
        .alu_operand_b (alu_operand_b),
        .opcode        (opcode),
        .flags         (flags),
        .state         (cpu_state)
    );

    alu i_alu (
        .clk       (clk),
        .reset     (reset),
        .op        (control_word.alu_op),
        .operand_a (alu_operand_a),
        .operand_b (alu_operand_b),
        .carry_in  (flags[FLAG_CARRY]),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    ram #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_ram (
        .clk   (clk),
        .addr  (mem_addr),
        .rdata (ram_rdata),
        .load  (load)
    );

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu import arch_defs_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int HOLD_CYCLES  = 20;

    logic        clk;
    logic        reset;
    mem_load_t   load;
    logic        halted;
    cpu_state_t  cpu_state;

    logic [15:0] byte_addr[$];                   // Program image, all tests
    logic [7:0]  byte_data[$];
    int          byte_test[$];                   // Owning test per byte
    int          test_bytes[$];
    cpu_state_t  expected[$];
    int          mismatch_count;
    int          other_count;
    int          watchdog_cycles;

    cpu_top #(
        .MEM_DEPTH (256)
    ) i_cpu_top (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .halted    (halted),
        .cpu_state (cpu_state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ================================================
    // Result checks
    task automatic check_state(input cpu_state_t got, input cpu_state_t exp, input string where);
        if (got.a !== exp.a) begin
            $display("MISMATCH %s cpu_state.a got %h expected %h", where, got.a, exp.a);
            mismatch_count++;
        end
        if (got.b !== exp.b) begin
            $display("MISMATCH %s cpu_state.b got %h expected %h", where, got.b, exp.b);
            mismatch_count++;
        end
        if (got.c !== exp.c) begin
            $display("MISMATCH %s cpu_state.c got %h expected %h", where, got.c, exp.c);
            mismatch_count++;
        end
        if (got.flags !== exp.flags) begin
            $display("MISMATCH %s cpu_state.flags got %h expected %h",
                     where, got.flags, exp.flags);
            mismatch_count++;
        end
        if (got.pc !== exp.pc) begin
            $display("MISMATCH %s cpu_state.pc got %h expected %h", where, got.pc, exp.pc);
            mismatch_count++;
        end
    endtask

    task automatic check_halt(input logic got, input string where);
        if (got !== 1'b1) begin
            $display("%s the CPU is not halted although the program should have stopped",
                     where);
            other_count++;
        end
    endtask

    // ================================================
    // Test data parsing
    task automatic read_testdata();
        int          fd;
        int          ch;
        int          n;
        int          count;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  c;
        logic [2:0]  f;
        logic [15:0] pc;
        count = 0;
        fd = $fopen("cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open cpu_testdata.txt");
            other_count++;
            return;
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while (ch != -1 && ch != "\n") ch = $fgetc(fd);   // Skip comment line
            end else if (ch == "M") begin
                n = $fscanf(fd, "%h %h", addr, data);
                if (n != 2) begin
                    $display("Malformed program byte line in cpu_testdata.txt");
                    other_count++;
                end else begin
                    byte_addr.push_back(addr);
                    byte_data.push_back(data);
                    byte_test.push_back(expected.size());
                    count++;
                end
            end else if (ch == "E") begin
                n = $fscanf(fd, "%h %h %h %h %h", a, b, c, f, pc);
                if (n != 5) begin
                    $display("Malformed expected state line in cpu_testdata.txt");
                    other_count++;
                end else begin
                    expected.push_back('{a: a, b: b, c: c, flags: f, pc: pc});
                    test_bytes.push_back(count);
                    count = 0;
                end
            end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
                $display("Unexpected character in cpu_testdata.txt");
                other_count++;
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // ================================================
    // Program load and run
    task automatic load_program(input int t);
        int i;
        int cycles;
        cycles = 0;
        @(posedge clk);
        reset <= 1'b1;
        for (i = 0; i < byte_addr.size(); i++) begin
            if (byte_test[i] == t) begin
                @(posedge clk);
                load <= '{en: 1'b1, addr: byte_addr[i], data: byte_data[i]};
                cycles++;
            end
        end
        @(posedge clk);
        load <= '0;
        cycles++;
        while (cycles < RESET_CYCLES) begin                 // At least 10 reset cycles
            @(posedge clk);
            cycles++;
        end
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int         limit;
        int         cycles;
        string      where;
        cpu_state_t held;
        where = $sformatf("test %0d", t);
        limit = 20 * test_bytes[t] + 50;
        load_program(t);
        cycles = 0;
        @(negedge clk);
        while (halted !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        check_halt(halted, where);
        if (halted === 1'b1) begin
            check_state(cpu_state, expected[t], where);
            held = cpu_state;
            for (cycles = 0; cycles < HOLD_CYCLES; cycles++) begin   // State must freeze
                @(negedge clk);
                check_halt(halted, {where, " after halt"});
                check_state(cpu_state, held, {where, " after halt"});
            end
        end
    endtask

    // ================================================
    // Main sequence
    initial begin
        int t;
        int total;
        reset = 1'b1;
        load = '0;
        mismatch_count = 0;
        other_count = 0;
        watchdog_cycles = 0;
        read_testdata();
        total = 0;
        for (t = 0; t < test_bytes.size(); t++) begin
            total += 40 * test_bytes[t] + 200;
        end
        watchdog_cycles = (total > 0) ? total : 200;
        if (expected.size() == 0) begin
            $display("No tests were found in cpu_testdata.txt");
            other_count++;
        end
        for (t = 0; t < expected.size(); t++) begin
            run_test(t);
        end
        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog, limit scales with program size
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("The run did not finish within %0d cycles", watchdog_cycles);
        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== cpu_testdata.txt ====
# Program byte lines     M addr data
# Expected state lines   E a b c flags pc   (flags bit 2 N, bit 1 C, bit 0 Z)
# Immediate loads then halt
M 0000 10
M 0001 05
M 0002 11
M 0003 80
M 0004 12
M 0005 00
M 0006 01
E 05 80 00 1 0007
# ADD wrap, INR keeps carry, ADC
M 0000 10
M 0001 FF
M 0002 11
M 0003 01
M 0004 20
M 0005 28
M 0006 22
M 0007 01
E 03 01 00 0 0008
# SUB borrow, DCR keeps carry, SBC
M 0000 10
M 0001 10
M 0002 12
M 0003 20
M 0004 25
M 0005 29
M 0006 27
M 0007 01
E CE 00 20 4 0008
# ANA_B clears carry, ANI, ANA_C
M 0000 10
M 0001 F3
M 0002 11
M 0003 9F
M 0004 20
M 0005 30
M 0006 12
M 0007 0F
M 0008 32
M 0009 81
M 000A 31
M 000B 01
E 00 9F 0F 1 000C
# LDA from 0020
M 0000 13
M 0001 20
M 0002 00
M 0003 01
M 0020 85
E 85 00 00 4 0004
# JMP, JZ taken, JNZ not taken
M 0000 10
M 0001 00
M 0002 40
M 0003 06
M 0004 00
M 0005 01
M 0006 41
M 0007 0A
M 0008 00
M 0009 01
M 000A 42
M 000B 05
M 000C 00
M 000D 12
M 000E 33
M 000F 01
E 00 00 33 0 0010
# JZ not taken, JNZ taken, JN not taken then taken
M 0000 10
M 0001 01
M 0002 41
M 0003 11
M 0004 00
M 0005 42
M 0006 09
M 0007 00
M 0008 01
M 0009 43
M 000A 11
M 000B 00
M 000C 10
M 000D 80
M 000E 43
M 000F 12
M 0010 00
M 0011 01
M 0012 12
M 0013 44
M 0014 01
E 80 00 44 0 0015

// ==== project.f ====
arch_defs_pkg.sv
alu.sv
control_unit.sv
datapath.sv
ram.sv
cpu_top.sv
tb_cpu.sv
